/* src/mem_pkg.sv */
package mem_pkg;

    // bus widths.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;

    // word store geometry.
    localparam int MEM_DEPTH = 256;
    localparam int IDX_W     = $clog2(MEM_DEPTH);

    // access latency in clock edges, counted from the accepting edge.
    localparam int LAT_W = 3;
    localparam logic [LAT_W-1:0] MEM_RD_LAT = 3'd3;
    // writes and any request with an error.
    localparam logic [LAT_W-1:0] MEM_WR_LAT = 3'd2;

    // arbiter grant loop, instruction side first.
    typedef enum logic [2:0] {
        I_CHECK,
        I_READY,
        I_VALID,
        D_CHECK,
        D_READY,
        D_VALID
    } arb_state_e;

    // response error type.
    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_ALIGN,
        ERR_RANGE
    } mem_err_e;

endpackage

/* src/mem_if.sv */
`timescale 1ns/1ns

// one request, held until valid and ready meet at a rising edge.
interface cache_req_if;

    logic                        valid;
    logic                        ready;
    logic [mem_pkg::ADDR_W-1:0]  addr;
    logic                        wen;
    logic [mem_pkg::DATA_W-1:0]  wdata;
    logic [mem_pkg::MASK_W-1:0]  wmask;

    modport client (
        output valid,
        input  ready,
        output addr,
        output wen,
        output wdata,
        output wmask
    );

    modport server (
        input  valid,
        output ready,
        input  addr,
        input  wen,
        input  wdata,
        input  wmask
    );

endinterface

// single-cycle response pulse, no back-pressure.
interface cache_resp_if;

    logic                        valid;
    logic                        error;
    mem_pkg::mem_err_e           errty;
    logic [mem_pkg::DATA_W-1:0]  rdata;

    modport source (
        output valid,
        output error,
        output errty,
        output rdata
    );

    modport sink (
        input  valid,
        input  error,
        input  errty,
        input  rdata
    );

endinterface

/* src/mem_latency_timer.sv */
`timescale 1ns/1ns

module mem_latency_timer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [mem_pkg::LAT_W-1:0]  cycles,
    output logic                       busy,
    output logic                       done
);

    logic [mem_pkg::LAT_W-1:0] count;

    assign busy = (count != '0);

    // done rises on the edge where the count drops to zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                count <= cycles;
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == mem_pkg::LAT_W'(1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/mem_cmd_arbiter.sv */
`timescale 1ns/1ns

module mem_cmd_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    cache_req_if.server        ireq,
    cache_req_if.server        dreq,
    cache_resp_if.source       iresp,
    cache_resp_if.source       dresp,
    cache_req_if.client        memreq,
    cache_resp_if.sink         memresp
);

    mem_pkg::arb_state_e state;
    mem_pkg::arb_state_e state_nxt;

    // request copies, replayed while the store is busy.
    logic [mem_pkg::ADDR_W-1:0] s_iaddr;
    logic                       s_iwen;
    logic [mem_pkg::DATA_W-1:0] s_iwdata;
    logic [mem_pkg::MASK_W-1:0] s_iwmask;
    logic [mem_pkg::ADDR_W-1:0] s_daddr;
    logic                       s_dwen;
    logic [mem_pkg::DATA_W-1:0] s_dwdata;
    logic [mem_pkg::MASK_W-1:0] s_dwmask;

    assign ireq.ready = (state == mem_pkg::I_CHECK);
    assign dreq.ready = (state == mem_pkg::D_CHECK);

    // memory command select.
    always_comb begin
        memreq.valid = 1'b0;
        memreq.addr  = '0;
        memreq.wen   = 1'b0;
        memreq.wdata = '0;
        memreq.wmask = '0;
        case (state)
            mem_pkg::I_CHECK: begin
                memreq.valid = ireq.valid;
                memreq.addr  = ireq.addr;
                memreq.wen   = ireq.wen;
                memreq.wdata = ireq.wdata;
                memreq.wmask = ireq.wmask;
            end
            mem_pkg::I_READY: begin
                memreq.valid = 1'b1;
                memreq.addr  = s_iaddr;
                memreq.wen   = s_iwen;
                memreq.wdata = s_iwdata;
                memreq.wmask = s_iwmask;
            end
            mem_pkg::D_CHECK: begin
                memreq.valid = dreq.valid;
                memreq.addr  = dreq.addr;
                memreq.wen   = dreq.wen;
                memreq.wdata = dreq.wdata;
                memreq.wmask = dreq.wmask;
            end
            mem_pkg::D_READY: begin
                memreq.valid = 1'b1;
                memreq.addr  = s_daddr;
                memreq.wen   = s_dwen;
                memreq.wdata = s_dwdata;
                memreq.wmask = s_dwmask;
            end
            default: begin
                memreq.valid = 1'b0;
            end
        endcase
    end

    // response goes back only to the side that owns the grant.
    assign iresp.valid = (state == mem_pkg::I_VALID) && memresp.valid;
    assign iresp.error = memresp.error;
    assign iresp.errty = memresp.errty;
    assign iresp.rdata = memresp.rdata;

    assign dresp.valid = (state == mem_pkg::D_VALID) && memresp.valid;
    assign dresp.error = memresp.error;
    assign dresp.errty = memresp.errty;
    assign dresp.rdata = memresp.rdata;

    always_comb begin
        state_nxt = state;
        case (state)
            mem_pkg::I_CHECK: begin
                if (!ireq.valid) begin
                    state_nxt = mem_pkg::D_CHECK;
                end else if (memreq.ready) begin
                    state_nxt = mem_pkg::I_VALID;
                end else begin
                    state_nxt = mem_pkg::I_READY;
                end
            end
            mem_pkg::I_READY: if (memreq.ready) state_nxt = mem_pkg::I_VALID;
            mem_pkg::I_VALID: if (memresp.valid) state_nxt = mem_pkg::D_CHECK;
            mem_pkg::D_CHECK: begin
                if (!dreq.valid) begin
                    state_nxt = mem_pkg::I_CHECK;
                end else if (memreq.ready) begin
                    state_nxt = mem_pkg::D_VALID;
                end else begin
                    state_nxt = mem_pkg::D_READY;
                end
            end
            mem_pkg::D_READY: if (memreq.ready) state_nxt = mem_pkg::D_VALID;
            mem_pkg::D_VALID: if (memresp.valid) state_nxt = mem_pkg::I_CHECK;
            default: state_nxt = mem_pkg::I_CHECK;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_pkg::I_CHECK;
        end else begin
            state <= state_nxt;
        end
    end

    // capture on the requester handshake.
    always_ff @(posedge clk) begin
        if (state == mem_pkg::I_CHECK && ireq.valid) begin
            s_iaddr  <= ireq.addr;
            s_iwen   <= ireq.wen;
            s_iwdata <= ireq.wdata;
            s_iwmask <= ireq.wmask;
        end
        if (state == mem_pkg::D_CHECK && dreq.valid) begin
            s_daddr  <= dreq.addr;
            s_dwen   <= dreq.wen;
            s_dwdata <= dreq.wdata;
            s_dwmask <= dreq.wmask;
        end
    end

endmodule

/* src/mem_store.sv */
`timescale 1ns/1ns

module mem_store (
    input  logic          clk,
    input  logic          rst_n,
    cache_req_if.server   req,
    cache_resp_if.source  resp
);

    logic [mem_pkg::DATA_W-1:0] mem [mem_pkg::MEM_DEPTH];

    logic                        accept;
    logic [mem_pkg::IDX_W-1:0]   idx;
    logic                        misaligned;
    logic                        out_of_range;
    mem_pkg::mem_err_e           err_ty;
    logic [mem_pkg::DATA_W-1:0]  cur_word;
    logic [mem_pkg::DATA_W-1:0]  merged_word;
    logic [mem_pkg::LAT_W-1:0]   lat;
    logic                        busy;
    logic                        done;

    logic                        resp_error_q;
    mem_pkg::mem_err_e           resp_errty_q;
    logic [mem_pkg::DATA_W-1:0]  resp_rdata_q;

    // idle only once the timer has run out and the response is gone.
    assign req.ready = !busy && !done;
    assign accept    = req.valid && req.ready;

    assign idx          = req.addr[mem_pkg::IDX_W+1:2];
    assign misaligned   = (req.addr[1:0] != 2'b00);
    assign out_of_range = req.addr[mem_pkg::ADDR_W-1:2] >=
                          (mem_pkg::ADDR_W-2)'(mem_pkg::MEM_DEPTH);

    // alignment is reported ahead of range.
    always_comb begin
        if (misaligned) begin
            err_ty = mem_pkg::ERR_ALIGN;
        end else if (out_of_range) begin
            err_ty = mem_pkg::ERR_RANGE;
        end else begin
            err_ty = mem_pkg::ERR_NONE;
        end
    end

    assign cur_word = mem[idx];

    always_comb begin
        for (int b = 0; b < mem_pkg::MASK_W; b++) begin
            merged_word[8*b +: 8] = req.wmask[b] ? req.wdata[8*b +: 8] : cur_word[8*b +: 8];
        end
    end

    assign lat = (req.wen || err_ty != mem_pkg::ERR_NONE) ? mem_pkg::MEM_WR_LAT
                                                         : mem_pkg::MEM_RD_LAT;

    mem_latency_timer u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (accept),
        .cycles (lat),
        .busy   (busy),
        .done   (done)
    );

    // contents read as zero after reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && req.wen && err_ty == mem_pkg::ERR_NONE) begin
            mem[idx] <= merged_word;
        end
    end

    // response payload, held until the timer fires.
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_error_q <= (err_ty != mem_pkg::ERR_NONE);
            resp_errty_q <= err_ty;
            if (err_ty != mem_pkg::ERR_NONE) begin
                resp_rdata_q <= '0;
            end else if (req.wen) begin
                resp_rdata_q <= merged_word;
            end else begin
                resp_rdata_q <= cur_word;
            end
        end
    end

    assign resp.valid = done;
    assign resp.error = resp_error_q;
    assign resp.errty = resp_errty_q;
    assign resp.rdata = resp_rdata_q;

endmodule

/* src/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        ireq_valid,
    output logic                        ireq_ready,
    input  logic [mem_pkg::ADDR_W-1:0]  ireq_addr,
    input  logic                        ireq_wen,
    input  logic [mem_pkg::DATA_W-1:0]  ireq_wdata,
    input  logic [mem_pkg::MASK_W-1:0]  ireq_wmask,
    output logic                        iresp_valid,
    output logic                        iresp_error,
    output mem_pkg::mem_err_e           iresp_errty,
    output logic [mem_pkg::DATA_W-1:0]  iresp_rdata,

    input  logic                        dreq_valid,
    output logic                        dreq_ready,
    input  logic [mem_pkg::ADDR_W-1:0]  dreq_addr,
    input  logic                        dreq_wen,
    input  logic [mem_pkg::DATA_W-1:0]  dreq_wdata,
    input  logic [mem_pkg::MASK_W-1:0]  dreq_wmask,
    output logic                        dresp_valid,
    output logic                        dresp_error,
    output mem_pkg::mem_err_e           dresp_errty,
    output logic [mem_pkg::DATA_W-1:0]  dresp_rdata
);

    cache_req_if  ireq_bus ();
    cache_req_if  dreq_bus ();
    cache_req_if  memreq_bus ();
    cache_resp_if iresp_bus ();
    cache_resp_if dresp_bus ();
    cache_resp_if memresp_bus ();

    // instruction side.
    assign ireq_bus.valid = ireq_valid;
    assign ireq_bus.addr  = ireq_addr;
    assign ireq_bus.wen   = ireq_wen;
    assign ireq_bus.wdata = ireq_wdata;
    assign ireq_bus.wmask = ireq_wmask;
    assign ireq_ready     = ireq_bus.ready;
    assign iresp_valid    = iresp_bus.valid;
    assign iresp_error    = iresp_bus.error;
    assign iresp_errty    = iresp_bus.errty;
    assign iresp_rdata    = iresp_bus.rdata;

    // data side.
    assign dreq_bus.valid = dreq_valid;
    assign dreq_bus.addr  = dreq_addr;
    assign dreq_bus.wen   = dreq_wen;
    assign dreq_bus.wdata = dreq_wdata;
    assign dreq_bus.wmask = dreq_wmask;
    assign dreq_ready     = dreq_bus.ready;
    assign dresp_valid    = dresp_bus.valid;
    assign dresp_error    = dresp_bus.error;
    assign dresp_errty    = dresp_bus.errty;
    assign dresp_rdata    = dresp_bus.rdata;

    mem_cmd_arbiter u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .ireq    (ireq_bus.server),
        .dreq    (dreq_bus.server),
        .iresp   (iresp_bus.source),
        .dresp   (dresp_bus.source),
        .memreq  (memreq_bus.client),
        .memresp (memresp_bus.sink)
    );

    mem_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (memreq_bus.server),
        .resp  (memresp_bus.source)
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for four rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* dv/mem_subsys_tb.sv */
`timescale 1ns/1ns

module mem_subsys_tb;

    localparam int N_TXN    = 60;
    localparam int WAIT_CYC = 2 * int'(mem_pkg::MEM_RD_LAT) + 4;
    localparam int CLK_NS   = 100;

    logic clk;
    logic rst_n;

    // index 0 is the instruction side, 1 the data side.
    logic                       req_valid [2];
    logic                       rdy       [2];
    logic [mem_pkg::ADDR_W-1:0] req_addr  [2];
    logic                       req_wen   [2];
    logic [mem_pkg::DATA_W-1:0] req_wdata [2];
    logic [mem_pkg::MASK_W-1:0] req_wmask [2];
    logic                       rsp_valid [2];
    logic                       rsp_error [2];
    mem_pkg::mem_err_e          rsp_errty [2];
    logic [mem_pkg::DATA_W-1:0] rsp_rdata [2];

    // reference model and per-port scoreboard.
    logic [31:0] model [mem_pkg::MEM_DEPTH];
    logic        pend    [2];
    int          cnt     [2];
    int          lat     [2];
    logic [34:0] exp_rsp [2];
    logic        idle    [2];
    int          last_src;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .ireq_valid  (req_valid[0]),
        .ireq_ready  (rdy[0]),
        .ireq_addr   (req_addr[0]),
        .ireq_wen    (req_wen[0]),
        .ireq_wdata  (req_wdata[0]),
        .ireq_wmask  (req_wmask[0]),
        .iresp_valid (rsp_valid[0]),
        .iresp_error (rsp_error[0]),
        .iresp_errty (rsp_errty[0]),
        .iresp_rdata (rsp_rdata[0]),
        .dreq_valid  (req_valid[1]),
        .dreq_ready  (rdy[1]),
        .dreq_addr   (req_addr[1]),
        .dreq_wen    (req_wen[1]),
        .dreq_wdata  (req_wdata[1]),
        .dreq_wmask  (req_wmask[1]),
        .dresp_valid (rsp_valid[1]),
        .dresp_error (rsp_error[1]),
        .dresp_errty (rsp_errty[1]),
        .dresp_rdata (rsp_rdata[1])
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // misalignment wins over range.
    function automatic mem_pkg::mem_err_e addr_error(input logic [31:0] addr);
        if (addr[1:0] != 2'b00) begin
            return mem_pkg::ERR_ALIGN;
        end
        if ((addr >> 2) >= 32'(mem_pkg::MEM_DEPTH)) begin
            return mem_pkg::ERR_RANGE;
        end
        return mem_pkg::ERR_NONE;
    endfunction

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("error: %s expected %0h actual %0h", name, exp, act);
        fail_run();
    endtask

    task automatic report_failure(input string msg);
        $display("error: %s", msg);
        fail_run();
    endtask

    // scoreboard update at every accepting edge.
    always @(posedge clk or negedge rst_n) begin : monitor
        mem_pkg::mem_err_e e;
        logic [31:0]       word;
        logic [31:0]       merged;
        int                idx;
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
                model[i] <= '0;
            end
            for (int p = 0; p < 2; p++) begin
                pend[p] <= 1'b0;
                cnt[p]  <= 0;
                lat[p]  <= 0;
                idle[p] <= 1'b0;
            end
            last_src <= -1;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (pend[p]) begin
                    cnt[p] <= cnt[p] + 1;
                end
                if (rsp_valid[p]) begin
                    pend[p] <= 1'b0;
                end
                if (rdy[p] && !req_valid[p]) begin
                    idle[p] <= 1'b1;
                end
                if (req_valid[p] && rdy[p]) begin
                    e   = addr_error(req_addr[p]);
                    idx = int'(req_addr[p][9:2]);
                    word = model[idx];
                    for (int b = 0; b < 4; b++) begin
                        merged[8*b +: 8] = req_wmask[p][b] ? req_wdata[p][8*b +: 8]
                                                           : word[8*b +: 8];
                    end
                    if (e != mem_pkg::ERR_NONE) begin
                        exp_rsp[p] <= {1'b1, e, 32'h0};
                    end else if (req_wen[p]) begin
                        model[idx] <= merged;
                        exp_rsp[p] <= {1'b0, e, merged};
                    end else begin
                        exp_rsp[p] <= {1'b0, e, word};
                    end
                    lat[p]   <= (req_wen[p] || e != mem_pkg::ERR_NONE) ?
                                int'(mem_pkg::MEM_WR_LAT) : int'(mem_pkg::MEM_RD_LAT);
                    pend[p]  <= 1'b1;
                    cnt[p]   <= 0;
                    last_src <= p;
                    idle[0]  <= 1'b0;
                    idle[1]  <= 1'b0;
                end
            end
        end
    end

    a_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rdy[0] && rdy[1]))
        else report_failure("both requesters were ready in the same cycle");

    for (genvar p = 0; p < 2; p++) begin : g_port
        a_route: assert property (@(posedge clk) disable iff (!rst_n)
                                  rsp_valid[p] |-> pend[p])
            else report_failure($sformatf("response on port %0d with nothing outstanding", p));

        a_lat: assert property (@(posedge clk) disable iff (!rst_n)
                                rsp_valid[p] |-> cnt[p] == lat[p])
            else report_mismatch($sformatf("latency port %0d", p),
                                 64'($sampled(lat[p])), 64'($sampled(cnt[p])));

        a_data: assert property (@(posedge clk) disable iff (!rst_n)
                                 rsp_valid[p] |->
                                 {rsp_error[p], rsp_errty[p], rsp_rdata[p]} == exp_rsp[p])
            else report_mismatch($sformatf("response port %0d", p),
                                 64'($sampled(exp_rsp[p])),
                                 64'({$sampled(rsp_error[p]), $sampled(rsp_errty[p]),
                                      $sampled(rsp_rdata[p])}));

        a_late: assert property (@(posedge clk) disable iff (!rst_n)
                                 !(pend[p] && cnt[p] > lat[p]))
            else report_failure($sformatf("response on port %0d never arrived", p));

        // a repeat grant is fine only if the other side skipped its turn.
        a_alt: assert property (@(posedge clk) disable iff (!rst_n)
                                (req_valid[p] && rdy[p] && last_src == p) |-> idle[1-p])
            else report_failure($sformatf("port %0d granted twice in a row", p));
    end

    task automatic drive_port(input int p);
        logic [31:0] r;
        int          kind;
        int          gap;
        r = 32'hc90c3c8f;
        if (p == 1) begin
            r = xorshift(r);
        end
        for (int n = 0; n < N_TXN; n++) begin
            r = xorshift(r);
            kind = int'(r % 10);
            gap  = int'(r[25:24] & r[27:26]);
            r = xorshift(r);
            // small window of words so reads hit earlier writes.
            req_addr[p] = r[31] ? {22'h0, r[7:0], 2'b00} : {26'h0, r[3:0], 2'b00};
            if (kind == 8) begin
                req_addr[p][1:0] = 2'b01 + 2'(r[9]);
            end else if (kind == 9) begin
                req_addr[p] = 32'h400 + {18'h0, r[15:4], 2'b00};
            end
            req_wen[p]   = (n != 0) && r[20];
            req_wmask[p] = r[13:10];
            r = xorshift(r);
            req_wdata[p] = r;
            @(posedge clk);
            #1 req_valid[p] = 1'b1;
            while (!rdy[p]) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1 req_valid[p] = 1'b0;
            while (!rsp_valid[p]) begin
                @(posedge clk);
                #1;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        for (int p = 0; p < 2; p++) begin
            req_valid[p] = 1'b0;
            req_addr[p]  = '0;
            req_wen[p]   = 1'b0;
            req_wdata[p] = '0;
            req_wmask[p] = '0;
        end
        @(posedge rst_n);
        #1;
        assert (rdy[0] && !rdy[1] && !rsp_valid[0] && !rsp_valid[1])
            else report_failure("ready or response state wrong after reset");
        fork
            drive_port(0);
            drive_port(1);
        join
        repeat (WAIT_CYC) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        #((2 * N_TXN * WAIT_CYC + 20) * CLK_NS);
        report_failure("simulation hung, requests did not complete in time");
    end

endmodule

/* flist.f */
src/mem_pkg.sv
src/mem_if.sv
src/mem_latency_timer.sv
src/mem_cmd_arbiter.sv
src/mem_store.sv
src/mem_subsys_top.sv
dv/tb_clock_gen.sv
dv/mem_subsys_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsys_tb -f flist.f \
    --Mdir obj_dir -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
